// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_store_queue
FLAGS     ?= --timing --assert
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Everything OK

SOURCES := $(wildcard design/*.sv tests/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f project.f --top-module $(TOP)

$(SIM_BIN): project.f $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) -f project.f --top-module $(TOP) --Mdir $(OBJ_DIR)

# The status of the pipe is that of grep
sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/lsq_pkg.sv ====
package lsq_pkg;

  localparam int WORD_ADDR_W = 61;
  localparam int DATA_W      = 64;

  // 8-byte aligned address, low three bits dropped
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

  typedef logic [DATA_W-1:0] data_t;

  // Stores dispatched in one cycle, 0 to 2
  typedef logic [1:0] dispatch_count_t;

  typedef struct packed {
    logic       executed;
    word_addr_t addr;
    data_t      data;
  } sq_entry_t;

  // Slot index travels beside it
  typedef struct packed {
    word_addr_t addr;
    data_t      data;
  } store_exec_t;

  typedef struct packed {
    word_addr_t addr;
    data_t      data;
  } cache_write_t;

  // Data is zero on a miss
  typedef struct packed {
    logic  hit;
    data_t data;
  } forward_t;

endpackage

// ==== design/sq_entries.sv ====
`timescale 1ns/1ps

module sq_entries #(
  parameter int  DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                dispatch_fire,
  input  lsq_pkg::dispatch_count_t            dispatch_count,
  input  logic [IDX_W-1:0]                    tail,
  input  logic                                exec_en,
  input  logic [IDX_W-1:0]                    exec_idx,
  input  lsq_pkg::store_exec_t                exec,
  input  logic [IDX_W-1:0]                    head,
  output lsq_pkg::sq_entry_t                  head_entry,
  output lsq_pkg::sq_entry_t [DEPTH-1:0]      entries
);

  import lsq_pkg::*;

  logic [DEPTH-1:0] executed;
  word_addr_t       addr_q [DEPTH];
  data_t            data_q [DEPTH];
  logic [IDX_W-1:0] second_slot;
  logic             alloc_first;
  logic             alloc_second;

  assign second_slot  = tail + IDX_W'(1);
  assign alloc_first  = dispatch_fire && (dispatch_count != 2'd0);
  assign alloc_second = dispatch_fire && (dispatch_count == 2'd2);

  // Execute comes last so it overrides a clear of the same slot
  always_ff @(posedge clock) begin
    if (reset) begin
      executed <= '0;
    end else begin
      if (alloc_first) begin
        executed[tail] <= 1'b0;
      end
      if (alloc_second) begin
        executed[second_slot] <= 1'b0;
      end
      if (exec_en) begin
        executed[exec_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_first) begin
      addr_q[tail] <= '0;
      data_q[tail] <= '0;
    end
    if (alloc_second) begin
      addr_q[second_slot] <= '0;
      data_q[second_slot] <= '0;
    end
    if (exec_en) begin
      addr_q[exec_idx] <= exec.addr;
      data_q[exec_idx] <= exec.data;
    end
  end

  // Flat view for the forwarding search
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      entries[i].executed = executed[i];
      entries[i].addr     = addr_q[i];
      entries[i].data     = data_q[i];
    end
  end

  assign head_entry = entries[head];

endmodule

// ==== design/sq_forward.sv ====
`timescale 1ns/1ps

module sq_forward #(
  parameter int  DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  lsq_pkg::sq_entry_t [DEPTH-1:0] entries,
  input  logic [IDX_W-1:0]               head,
  input  lsq_pkg::word_addr_t            load_addr,
  input  logic [IDX_W-1:0]               load_age,
  output lsq_pkg::forward_t              forward
);

  // Number of stores older than the load
  logic [IDX_W-1:0]            age_span;
  // Slot index for each age position, oldest first
  logic [DEPTH-1:0][IDX_W-1:0] slot_of;
  logic [DEPTH-1:0]            match;

  assign age_span = load_age - head;

  always_comb begin
    for (int j = 0; j < DEPTH; j++) begin
      slot_of[j] = head + IDX_W'(j);
    end
  end

  always_comb begin
    for (int j = 0; j < DEPTH; j++) begin
      match[j] = (IDX_W'(j) < age_span)
              && entries[slot_of[j]].executed
              && (entries[slot_of[j]].addr == load_addr);
    end
  end

  // Scan oldest to youngest, the last match is the youngest older store
  always_comb begin
    forward = '0;
    for (int j = 0; j < DEPTH; j++) begin
      if (match[j]) begin
        forward.hit  = 1'b1;
        forward.data = entries[slot_of[j]].data;
      end
    end
  end

endmodule

// ==== design/sq_pointers.sv ====
`timescale 1ns/1ps

module sq_pointers #(
  parameter int  DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch_en,
  input  lsq_pkg::dispatch_count_t dispatch_count,
  input  logic                     rollback_en,
  input  logic [IDX_W-1:0]         rollback_idx,
  input  logic                     retire_request,
  input  logic                     retire_en,
  input  logic                     cache_ready,
  output logic [IDX_W-1:0]         head,
  output logic [IDX_W-1:0]         tail,
  output logic                     dispatch_ready,
  output logic                     empty,
  output logic                     retire_fire
);

  logic [IDX_W-1:0] tail_plus_one;
  logic [IDX_W-1:0] tail_plus_two;
  logic [IDX_W-1:0] tail_advanced;
  logic [IDX_W-1:0] next_tail;
  logic             dispatch_fire;

  // Ring indices wrap modulo DEPTH, so DEPTH is a power of two
  assign tail_plus_one = tail + IDX_W'(1);
  assign tail_plus_two = tail + IDX_W'(2);

  // One slot always stays free so a full ring differs from an empty one
  always_comb begin
    case (dispatch_count)
      2'd0: begin
        dispatch_ready = 1'b1;
        tail_advanced  = tail;
      end
      2'd1: begin
        dispatch_ready = tail_plus_one != head;
        tail_advanced  = tail_plus_one;
      end
      default: begin
        dispatch_ready = (tail_plus_one != head) && (tail_plus_two != head);
        tail_advanced  = tail_plus_two;
      end
    endcase
  end

  assign dispatch_fire = dispatch_en && dispatch_ready;
  assign empty         = head == tail;

  // Head store leaves only when the cache takes it
  assign retire_fire = retire_en && !empty && retire_request && cache_ready;

  // Rollback wins over dispatch
  always_comb begin
    if (rollback_en) begin
      next_tail = rollback_idx;
    end else if (dispatch_fire) begin
      next_tail = tail_advanced;
    end else begin
      next_tail = tail;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      tail <= next_tail;
      if (retire_fire) begin
        head <= head + IDX_W'(1);
      end
    end
  end

endmodule

// ==== design/store_queue.sv ====
`timescale 1ns/1ps

module store_queue #(
  parameter int  DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch_en,
  input  lsq_pkg::dispatch_count_t dispatch_count,
  input  logic                     exec_en,
  input  logic [IDX_W-1:0]         exec_idx,
  input  lsq_pkg::store_exec_t     exec,
  input  logic                     retire_en,
  input  logic                     cache_ready,
  input  lsq_pkg::word_addr_t      load_addr,
  input  logic [IDX_W-1:0]         load_age,
  input  logic                     rollback_en,
  input  logic [IDX_W-1:0]         rollback_idx,
  output logic                     dispatch_ready,
  output logic [IDX_W-1:0]         alloc_idx_a,
  output logic [IDX_W-1:0]         alloc_idx_b,
  output logic                     cache_wr_en,
  output lsq_pkg::cache_write_t    cache_wr,
  output logic                     store_retired,
  output lsq_pkg::forward_t        forward
);

  import lsq_pkg::*;

  logic                  [IDX_W-1:0] head;
  logic                  [IDX_W-1:0] tail;
  logic                              empty;
  logic                              retire_fire;
  logic                              dispatch_fire;
  sq_entry_t                         head_entry;
  sq_entry_t [DEPTH-1:0]             entries;

  assign dispatch_fire = dispatch_en && dispatch_ready;
  assign alloc_idx_a   = tail;
  assign alloc_idx_b   = tail + IDX_W'(1);

  // Head write stays on the bus until the cache is ready
  assign cache_wr_en   = retire_en && !empty && head_entry.executed;
  assign cache_wr.addr = head_entry.addr;
  assign cache_wr.data = head_entry.data;
  assign store_retired = retire_fire;

  sq_pointers #(.DEPTH(DEPTH)) u_pointers (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .dispatch_count (dispatch_count),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .retire_request (head_entry.executed),
    .retire_en      (retire_en),
    .cache_ready    (cache_ready),
    .head           (head),
    .tail           (tail),
    .dispatch_ready (dispatch_ready),
    .empty          (empty),
    .retire_fire    (retire_fire)
  );

  sq_entries #(.DEPTH(DEPTH)) u_entries (
    .clock          (clock),
    .reset          (reset),
    .dispatch_fire  (dispatch_fire),
    .dispatch_count (dispatch_count),
    .tail           (tail),
    .exec_en        (exec_en),
    .exec_idx       (exec_idx),
    .exec           (exec),
    .head           (head),
    .head_entry     (head_entry),
    .entries        (entries)
  );

  sq_forward #(.DEPTH(DEPTH)) u_forward (
    .entries   (entries),
    .head      (head),
    .load_addr (load_addr),
    .load_age  (load_age),
    .forward   (forward)
  );

endmodule

// ==== project.f ====
design/lsq_pkg.sv
design/sq_pointers.sv
design/sq_entries.sv
design/sq_forward.sv
design/store_queue.sv
tests/store_queue_asserts.sv
tests/tb_store_queue.sv

// ==== tests/sq_patterns.txt ====
# in:  disp_en disp_cnt exec_en exec_idx exec_addr exec_data retire_en cache_ready load_addr load_age rb_en rb_idx
# out: ready alloc_a alloc_b wr_en wr_addr wr_data retired fwd_hit fwd_data (all hex)
@ dispatch filling
1 2 0 0 0 0 0 0 0 0 0 0        1 0 1 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0        1 2 3 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0        1 3 4 0 0 0 0 0 0
1 2 0 0 0 0 0 0 0 0 0 0        1 3 4 0 0 0 0 0 0
1 2 0 0 0 0 0 0 0 0 0 0        1 5 6 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0        0 7 0 0 0 0 0 0 0
0 2 0 0 0 0 0 0 0 0 0 0        0 7 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0        1 7 0 0 0 0 0 0 0
@ out-of-order execute, in-order retire with back-pressure
0 0 1 2 102 a2 0 0 0 0 0 0     1 7 0 0 0 0 0 0 0
0 0 1 0 100 a0 0 0 0 0 0 0     1 7 0 0 0 0 0 0 0
0 0 1 1 101 a1 1 0 0 0 0 0     1 7 0 1 100 a0 0 0 0
0 0 0 0 0 0 1 0 0 0 0 0        1 7 0 1 100 a0 0 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 7 0 1 100 a0 1 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 7 0 1 101 a1 1 0 0
0 0 0 0 0 0 1 0 0 0 0 0        1 7 0 1 102 a2 0 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 7 0 1 102 a2 1 0 0
@ no retire before the head executes
0 0 1 4 104 b4 1 1 0 0 0 0     1 7 0 0 0 0 0 0 0
0 0 1 3 103 b3 1 1 0 0 0 0     1 7 0 0 0 0 0 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 7 0 1 103 b3 1 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 7 0 1 104 b4 1 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 7 0 0 0 0 0 0 0
@ youngest older store forwarding
0 0 1 5 200 c5 0 0 0 0 0 0     1 7 0 0 0 0 0 0 0
0 0 1 6 200 c6 0 0 200 7 0 0   1 7 0 0 0 0 0 1 c5
0 0 0 0 0 0 0 0 200 7 0 0      1 7 0 0 0 0 0 1 c6
0 0 0 0 0 0 0 0 200 6 0 0      1 7 0 0 0 0 0 1 c5
0 0 0 0 0 0 0 0 201 7 0 0      1 7 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 200 5 0 0      1 7 0 0 0 0 0 0 0
@ rollback
0 0 0 0 0 0 0 0 200 7 1 6      1 7 0 0 0 0 0 1 c6
1 1 0 0 0 0 0 0 0 0 0 0        1 6 7 0 0 0 0 0 0
0 0 0 0 0 0 0 0 200 7 0 0      1 7 0 0 0 0 0 1 c5
1 2 0 0 0 0 0 0 0 0 1 5        1 7 0 0 0 0 0 0 0
0 0 0 0 0 0 1 1 200 5 0 0      1 5 6 0 0 0 0 0 0
1 2 0 0 0 0 0 0 0 0 0 0        1 5 6 0 0 0 0 0 0
0 0 0 0 0 0 1 1 200 7 0 0      1 7 0 0 0 0 0 0 0
@ wrap-around
1 2 0 0 0 0 0 0 0 0 0 0        1 7 0 0 0 0 0 0 0
1 2 0 0 0 0 0 0 0 0 0 0        1 1 2 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0        1 3 4 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0        0 4 5 0 0 0 0 0 0
0 0 1 0 300 e0 0 0 0 0 0 0     1 4 5 0 0 0 0 0 0
0 0 1 7 300 e7 0 0 0 0 0 0     1 4 5 0 0 0 0 0 0
0 0 1 5 300 e5 0 0 300 1 0 0   1 4 5 0 0 0 0 1 e0
0 0 1 6 301 e6 0 0 300 0 0 0   1 4 5 0 0 0 0 1 e7
0 0 0 0 0 0 1 1 300 6 0 0      1 4 5 1 300 e5 1 1 e5
0 0 0 0 0 0 1 0 300 1 0 0      1 4 5 1 301 e6 0 1 e0
0 0 0 0 0 0 1 1 0 0 0 0        1 4 5 1 301 e6 1 0 0
0 0 0 0 0 0 1 1 0 0 0 0        1 4 5 1 300 e7 1 0 0
0 0 0 0 0 0 1 1 300 1 0 0      1 4 5 1 300 e0 1 1 e0
1 2 0 0 0 0 1 1 0 0 0 0        1 4 5 0 0 0 0 0 0
0 0 0 0 0 0 0 0 300 6 0 0      1 6 7 0 0 0 0 0 0

// ==== tests/store_queue_asserts.sv ====
`timescale 1ns/1ps

module store_queue_asserts #(
  parameter int  DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input logic                     clock,
  input logic                     reset,
  input logic                     dispatch_en,
  input lsq_pkg::dispatch_count_t dispatch_count,
  input logic                     dispatch_ready,
  input logic                     rollback_en,
  input logic                     cache_wr_en,
  input logic                     cache_ready,
  input lsq_pkg::cache_write_t    cache_wr,
  input logic                     empty,
  input logic [IDX_W-1:0]         head,
  input logic [IDX_W-1:0]         tail
);

  int unsigned empty_failures  = 0;
  int unsigned stable_failures = 0;
  int unsigned tail_failures   = 0;
  int unsigned failures;

  assign failures = empty_failures + stable_failures + tail_failures;

  // Without dispatch or rollback an empty queue stays empty
  no_write_when_empty: assert property (@(posedge clock) disable iff (reset)
    (empty && !dispatch_en && !rollback_en) |=> !cache_wr_en)
  else begin
    empty_failures++;
    $error("cache write raised while the store queue stayed empty");
  end

  // Back-pressure holds the head write on the bus
  write_held_when_stalled: assert property (@(posedge clock) disable iff (reset)
    (cache_wr_en && !cache_ready) |=> $stable(cache_wr))
  else begin
    stable_failures++;
    $error("cache write changed while the cache was not ready");
  end

  tail_clear_of_head: assert property (@(posedge clock) disable iff (reset)
    (dispatch_en && dispatch_ready && (dispatch_count != 2'd0) && !rollback_en)
      |=> (tail != head))
  else begin
    tail_failures++;
    $error("tail caught up with head after a dispatch");
  end

endmodule

// ==== tests/tb_store_queue.sv ====
`timescale 1ns/1ps

module tb_store_queue;

  import lsq_pkg::*;

  localparam int DEPTH      = 8;
  localparam int IDX_W      = $clog2(DEPTH);
  localparam int FIELDS     = 21;
  localparam int MAX_CYCLES = 2000;
  localparam int MAX_IDLE   = 4;

  logic             clock;
  logic             reset;
  logic             dispatch_en;
  dispatch_count_t  dispatch_count;
  logic             exec_en;
  logic [IDX_W-1:0] exec_idx;
  store_exec_t      exec;
  logic             retire_en;
  logic             cache_ready;
  word_addr_t       load_addr;
  logic [IDX_W-1:0] load_age;
  logic             rollback_en;
  logic [IDX_W-1:0] rollback_idx;
  logic             dispatch_ready;
  logic [IDX_W-1:0] alloc_idx_a;
  logic [IDX_W-1:0] alloc_idx_b;
  logic             cache_wr_en;
  cache_write_t     cache_wr;
  logic             store_retired;
  forward_t         forward;

  // One pattern line, inputs then expected outputs
  logic [63:0]      field [FIELDS];
  int               line_no;

  store_queue #(.DEPTH(DEPTH)) i_dut (.*);

  bind store_queue store_queue_asserts #(.DEPTH(DEPTH)) i_asserts (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .dispatch_count (dispatch_count),
    .dispatch_ready (dispatch_ready),
    .rollback_en    (rollback_en),
    .cache_wr_en    (cache_wr_en),
    .cache_ready    (cache_ready),
    .cache_wr       (cache_wr),
    .empty          (empty),
    .head           (head),
    .tail           (tail)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic drive_idle();
    dispatch_en    = 1'b0;
    dispatch_count = '0;
    exec_en        = 1'b0;
    exec_idx       = '0;
    exec           = '0;
    retire_en      = 1'b0;
    cache_ready    = 1'b0;
    load_addr      = '0;
    load_age       = '0;
    rollback_en    = 1'b0;
    rollback_idx   = '0;
  endtask

  task automatic apply_fields();
    dispatch_en    = field[0][0];
    dispatch_count = field[1][1:0];
    exec_en        = field[2][0];
    exec_idx       = field[3][IDX_W-1:0];
    exec.addr      = field[4][WORD_ADDR_W-1:0];
    exec.data      = field[5];
    retire_en      = field[6][0];
    cache_ready    = field[7][0];
    load_addr      = field[8][WORD_ADDR_W-1:0];
    load_age       = field[9][IDX_W-1:0];
    rollback_en    = field[10][0];
    rollback_idx   = field[11][IDX_W-1:0];
  endtask

  task automatic check_dispatch(
    input logic             got_ready,
    input logic [IDX_W-1:0] got_a,
    input logic [IDX_W-1:0] got_b,
    input logic             want_ready,
    input logic [IDX_W-1:0] want_a,
    input logic [IDX_W-1:0] want_b
  );
    if (got_ready !== want_ready) begin
      abort_run($sformatf("MISMATCH line %0d dispatch_ready: got %h, expected %h",
                          line_no, got_ready, want_ready));
    end else if (got_a !== want_a) begin
      abort_run($sformatf("MISMATCH line %0d alloc_idx_a: got %h, expected %h",
                          line_no, got_a, want_a));
    end else if (got_b !== want_b) begin
      abort_run($sformatf("MISMATCH line %0d alloc_idx_b: got %h, expected %h",
                          line_no, got_b, want_b));
    end
  endtask

  // Bus contents only matter while the enable is up
  task automatic check_cache_write(
    input logic         got_en,
    input cache_write_t got_wr,
    input logic         got_retired,
    input logic         want_en,
    input cache_write_t want_wr,
    input logic         want_retired
  );
    if (got_en !== want_en) begin
      abort_run($sformatf("MISMATCH line %0d cache_wr_en: got %h, expected %h",
                          line_no, got_en, want_en));
    end else if (want_en && (got_wr !== want_wr)) begin
      abort_run($sformatf("MISMATCH line %0d cache_wr: got %h, expected %h",
                          line_no, got_wr, want_wr));
    end else if (got_retired !== want_retired) begin
      abort_run($sformatf("MISMATCH line %0d store_retired: got %h, expected %h",
                          line_no, got_retired, want_retired));
    end
  endtask

  task automatic check_forward(input forward_t got, input forward_t want);
    if (got.hit !== want.hit) begin
      abort_run($sformatf("MISMATCH line %0d forward.hit: got %h, expected %h",
                          line_no, got.hit, want.hit));
    end else if (got.data !== want.data) begin
      abort_run($sformatf("MISMATCH line %0d forward.data: got %h, expected %h",
                          line_no, got.data, want.data));
    end
  endtask

  task automatic check_outputs();
    cache_write_t want_wr;
    forward_t     want_fwd;
    want_wr.addr  = field[16][WORD_ADDR_W-1:0];
    want_wr.data  = field[17];
    want_fwd.hit  = field[19][0];
    want_fwd.data = field[20];
    check_dispatch(dispatch_ready, alloc_idx_a, alloc_idx_b,
                   field[12][0], field[13][IDX_W-1:0], field[14][IDX_W-1:0]);
    check_cache_write(cache_wr_en, cache_wr, store_retired,
                      field[15][0], want_wr, field[18][0]);
    check_forward(forward, want_fwd);
  endtask

  initial begin
    int    fd;
    int    count;
    int    cycles;
    int    idle;
    string line;
    void'($urandom(32'h1e9c));
    drive_idle();
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;

    fd = $fopen("tests/sq_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the pattern file tests/sq_patterns.txt");
    end
    cycles  = 0;
    line_no = 0;
    while (!$feof(fd)) begin
      if (cycles > MAX_CYCLES) begin
        abort_run("pattern loop ran past its cycle limit");
      end
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      // Block start, quiet cycles leave the queue state alone
      if (line[0] == "@") begin
        idle = $urandom % MAX_IDLE;
        repeat (idle) begin
          @(posedge clock);
          #1 drive_idle();
          cycles++;
        end
        continue;
      end
      count = $sscanf(line,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        field[0], field[1], field[2], field[3], field[4], field[5], field[6],
        field[7], field[8], field[9], field[10], field[11], field[12], field[13],
        field[14], field[15], field[16], field[17], field[18], field[19], field[20]);
      if (count != FIELDS) begin
        abort_run($sformatf("pattern line %0d holds %0d fields instead of %0d",
                            line_no, count, FIELDS));
      end
      @(posedge clock);
      #1 apply_fields();
      #8 check_outputs();
      if (i_dut.i_asserts.failures != 0) begin
        abort_run("a bound assertion on the store queue reported an error");
      end
      cycles++;
    end
    $fclose(fd);

    // Let the last implications complete
    repeat (2) begin
      @(posedge clock);
      #1 drive_idle();
    end
    if (i_dut.i_asserts.failures == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("a bound assertion on the store queue reported an error");
    end
  end

endmodule
